// ==== Makefile ====
SRCS := $(wildcard source/*.sv source/*.svh dv/*.sv)

all: run

obj_dir/Vfire_expand_tb: $(SRCS) sources.f
	verilator --binary --timing -Wno-fatal --top-module fire_expand_tb -f sources.f

run: obj_dir/Vfire_expand_tb
	obj_dir/Vfire_expand_tb | tee sim.log
	@if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== dv/fire_expand_patterns.txt ====
// rows 0-3: 1x1 window bases, rows 4-7: 3x3 window bases, pixel = base + tap
// rows 8-39: expected words per pixel, 1x1 ch 0-3 then 3x3 ch 0-3
4000
2000
E000
1000
2000
4000
FFF0
0800
// pixel 0
2201
1C00
0000
1604
1E10
144F
0F09
2776
// pixel 1
1101
0E00
0000
0B04
3C10
28EF
1E09
4ED6
// pixel 2, mostly zeroed by relu
0000
0000
0185
0000
0001
0000
0001
0002
// pixel 3
0881
0700
0000
0584
0790
04D7
03C9
09EE

// ==== dv/fire_expand_tb.sv ====
`include "fire_config.svh"

module fire_expand_tb;

	localparam int NWIN    = `FIRE_WOUT * `FIRE_WOUT;
	localparam int TAPS1   = `FIRE_CHIN;
	localparam int TAPS3   = 9 * `FIRE_CHIN;
	localparam int NOUT    = 2 * `FIRE_NCH;
	localparam int NWORDS  = NWIN * NOUT;
	localparam int NPAT    = 2 * NWIN + NWORDS;
	localparam int TIMEOUT = 4 * NWIN * (TAPS1 + TAPS3) + 200;

	logic                   clk;
	logic                   rst;
	logic                   en1;
	logic [`FIRE_WIDTH-1:0] ifm1;
	logic                   en3;
	logic [`FIRE_WIDTH-1:0] ifm3;
	logic                   ack;
	logic                   out_valid;
	logic [2:0]             out_ch;
	logic [`FIRE_WIDTH-1:0] out_data;
	logic                   finish;

	// window bases of both streams, then expected words
	logic [`FIRE_WIDTH-1:0] pat [NPAT];
	int                     gap1 [NWIN];
	int                     gap3 [NWIN];
	int                     words_seen;
	int                     errors;
	int                     cycles;
	logic                   early_finish;
	logic [31:0]            seed_ret;

	fire_expand_top i_dut (
		.clk      (clk),
		.rst      (rst),
		.en1      (en1),
		.ifm1     (ifm1),
		.en3      (en3),
		.ifm3     (ifm3),
		.ack      (ack),
		.out_valid(out_valid),
		.out_ch   (out_ch),
		.out_data (out_data),
		.finish   (finish)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// pixel is window base plus tap index
	task automatic drive_1x1();
		for (int w = 0; w < NWIN; w++) begin
			// previous pair must have left the serialiser
			while (words_seen < w * NOUT) begin
				@(posedge clk);
			end
			repeat (gap1[w]) @(negedge clk);
			for (int t = 0; t < TAPS1; t++) begin
				@(negedge clk);
				en1  = 1'b1;
				ifm1 = pat[w] + 16'(t);
			end
			@(negedge clk);
			en1 = 1'b0;
		end
	endtask

	// 3x3 windows are long enough to run without waiting
	task automatic drive_3x3();
		for (int w = 0; w < NWIN; w++) begin
			repeat (gap3[w]) @(negedge clk);
			for (int t = 0; t < TAPS3; t++) begin
				@(negedge clk);
				en3  = 1'b1;
				ifm3 = pat[NWIN + w] + 16'(t);
			end
			@(negedge clk);
			en3 = 1'b0;
		end
	endtask

	// words of a group must come back to back
	initial begin
		forever begin
			@(negedge clk);
			if (rst) begin
				if (out_valid) begin
					if (words_seen < NWORDS) begin
						check_value("out_ch", words_seen % NOUT, out_ch);
						check_value("out_data", pat[2 * NWIN + words_seen], out_data);
					end else begin
						errors++;
						$display("output word on channel %0d after the last group", out_ch);
					end
					words_seen++;
				end else if (words_seen % NOUT != 0) begin
					check_value("out_valid", 1, out_valid);
				end
				if (finish && words_seen < NWORDS && !early_finish) begin
					errors++;
					early_finish = 1'b1;
					$display("finish went high after only %0d output words", words_seen);
				end
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped after %0d cycles without reaching the end", cycles);
		$display("%0d errors, %0d output words", errors, words_seen);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		rst          = 1'b0;
		en1          = 1'b0;
		ifm1         = '0;
		en3          = 1'b0;
		ifm3         = '0;
		ack          = 1'b0;
		words_seen   = 0;
		errors       = 0;
		early_finish = 1'b0;
		seed_ret     = $urandom(32'h8e2dc09d);
		for (int w = 0; w < NWIN; w++) begin
			gap1[w] = $urandom % 4;
			gap3[w] = $urandom % 4;
		end
		$readmemh("dv/fire_expand_patterns.txt", pat);

		repeat (16) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check_value("out_valid", 0, out_valid);
		check_value("finish", 0, finish);

		fork
			drive_1x1();
			drive_3x3();
		join

		while (!finish) begin
			@(negedge clk);
		end
		check_value("words_seen", NWORDS, words_seen);

		// one ack pulse ends the layer
		@(negedge clk);
		ack = 1'b1;
		@(negedge clk);
		ack = 1'b0;
		repeat (4) begin
			@(negedge clk);
			check_value("finish", 0, finish);
		end

		$display("%0d errors, %0d output words", errors, words_seen);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== source/expand_conv.sv ====
`include "fire_config.svh"

module expand_conv #(
	parameter fire_pkg::kernel_sel_t SEL = fire_pkg::KSEL_1X1
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   en,
	input  logic [`FIRE_WIDTH-1:0] ifm,
	output logic                   sample,
	output logic                   done,
	output logic [`FIRE_WIDTH-1:0] ofm [`FIRE_NCH]
);

	localparam int TAPS = (SEL == fire_pkg::KSEL_1X1) ? `FIRE_CHIN : 9 * `FIRE_CHIN;
	localparam int NWIN = `FIRE_WOUT * `FIRE_WOUT;

	logic [`FIRE_TAP_W-1:0]         tap;
	logic [$clog2(NWIN):0]          win_cnt;
	logic                           accept;
	logic                           last_tap;
	logic                           en_r;
	logic                           win_end;
	logic                           clr;
	logic signed [`FIRE_WIDTH-1:0]  pix_r;
	logic signed [`FIRE_WIDTH-1:0]  ker_w  [`FIRE_NCH];
	logic signed [`FIRE_WIDTH-1:0]  ker_r  [`FIRE_NCH];
	logic signed [`FIRE_ACC_W-1:0]  bias   [`FIRE_NCH];
	logic signed [`FIRE_ACC_W-1:0]  acc    [`FIRE_NCH];
	logic signed [`FIRE_ACC_W-1:0]  biased [`FIRE_NCH];

	// input is ignored once every window has been taken
	assign accept   = en && (win_cnt != NWIN);
	assign last_tap = accept && (tap == TAPS - 1);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap     <= '0;
			win_cnt <= '0;
		end else if (accept) begin
			if (last_tap) begin
				tap     <= '0;
				win_cnt <= win_cnt + 1'b1;
			end else begin
				tap <= tap + 1'b1;
			end
		end
	end

	expand_rom #(
		.SEL(SEL)
	) i_rom (
		.addr(tap),
		.ker (ker_w),
		.bias(bias)
	);

	// pixel and its weights enter the MACs together
	always_ff @(posedge clk) begin
		if (accept) begin
			pix_r <= ifm;
			ker_r <= ker_w;
		end
	end

	// win_end lines up with the last product, clr with the full sum
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			en_r    <= 1'b0;
			win_end <= 1'b0;
			clr     <= 1'b0;
			sample  <= 1'b0;
			done    <= 1'b0;
		end else begin
			en_r    <= accept;
			win_end <= last_tap;
			clr     <= win_end;
			sample  <= clr;
			if (clr && (win_cnt == NWIN)) begin
				done <= 1'b1;
			end
		end
	end

	for (genvar i = 0; i < `FIRE_NCH; i++) begin : g_lane
		mac i_mac (
			.clk(clk),
			.rst(rst),
			.clr(clr),
			.en (en_r),
			.pix(pix_r),
			.ker(ker_r[i]),
			.acc(acc[i])
		);
	end

	always_comb begin
		for (int i = 0; i < `FIRE_NCH; i++) begin
			biased[i] = acc[i] + bias[i];
		end
	end

	// relu, then drop the fraction and keep a clear sign bit
	always_ff @(posedge clk) begin
		if (clr) begin
			for (int i = 0; i < `FIRE_NCH; i++) begin
				if (biased[i][`FIRE_ACC_W-1]) begin
					ofm[i] <= '0;
				end else begin
					ofm[i] <= {1'b0, biased[i][`FIRE_FRAC +: `FIRE_WIDTH-1]};
				end
			end
		end
	end

endmodule

// ==== source/expand_rom.sv ====
`include "fire_config.svh"

module expand_rom #(
	parameter fire_pkg::kernel_sel_t SEL = fire_pkg::KSEL_1X1
) (
	input  logic        [`FIRE_TAP_W-1:0] addr,
	output logic signed [`FIRE_WIDTH-1:0] ker  [`FIRE_NCH],
	output logic signed [`FIRE_ACC_W-1:0] bias [`FIRE_NCH]
);

	logic [`FIRE_NCH-1:0][`FIRE_WIDTH-1:0] row;
	logic [`FIRE_NCH-1:0][`FIRE_ACC_W-1:0] brow;
	logic [`FIRE_TAP_W-1:0]                pos;
	logic [`FIRE_TAP_W-1:0]                cin;

	// 3x3 taps run input channel fastest
	assign pos = addr / `FIRE_CHIN;
	assign cin = addr % `FIRE_CHIN;

	// rows list channel 3 first
	always_comb begin
		row = '0;
		if (SEL == fire_pkg::KSEL_1X1) begin
			case (addr)
				6'd0: row = {16'sd4096, -16'sd2048, 16'sd8192, 16'sd1024};
				6'd1: row = {-16'sd1024, 16'sd3072, 16'sd2048, -16'sd512};
				6'd2: row = {16'sd2048, 16'sd1024, -16'sd4096, 16'sd6144};
				6'd3: row = {16'sd512, -16'sd3072, 16'sd1024, 16'sd2048};
				default: row = '0;
			endcase
			brow = {`FIRE_ACC_W'(65536), `FIRE_ACC_W'(-2000000),
				`FIRE_ACC_W'(16384), `FIRE_ACC_W'(0)};
		end else begin
			case (pos)
				6'd0: row = {16'sd2048, 16'sd1024, -16'sd1024, 16'sd512};
				6'd1: row = {16'sd1024, -16'sd2048, 16'sd2048, 16'sd1024};
				6'd2: row = {-16'sd512, 16'sd1024, 16'sd1024, 16'sd2048};
				6'd3: row = {16'sd1024, 16'sd512, -16'sd2048, 16'sd1024};
				6'd4: row = {16'sd4096, 16'sd2048, 16'sd4096, -16'sd1024};
				6'd5: row = {16'sd1024, -16'sd512, 16'sd1024, 16'sd1024};
				6'd6: row = {-16'sd1024, 16'sd1024, 16'sd512, 16'sd2048};
				6'd7: row = {16'sd1024, 16'sd2048, -16'sd1024, 16'sd512};
				6'd8: row = {16'sd2048, -16'sd1024, 16'sd1024, 16'sd1024};
				default: row = '0;
			endcase
			brow = {`FIRE_ACC_W'(32768), `FIRE_ACC_W'(0),
				`FIRE_ACC_W'(-1500000), `FIRE_ACC_W'(8192)};
		end
		for (int i = 0; i < `FIRE_NCH; i++) begin
			// each deeper input channel halves the spatial weight
			if (SEL == fire_pkg::KSEL_3X3) begin
				ker[i] = $signed(row[i]) >>> cin;
			end else begin
				ker[i] = row[i];
			end
			bias[i] = brow[i];
		end
	end

endmodule

// ==== source/fire_concat.sv ====
`include "fire_config.svh"

module fire_concat (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   s1,
	input  logic [`FIRE_WIDTH-1:0] ofm1 [`FIRE_NCH],
	input  logic                   s3,
	input  logic [`FIRE_WIDTH-1:0] ofm3 [`FIRE_NCH],
	input  logic                   done1,
	input  logic                   done3,
	input  logic                   ack,
	output logic                   out_valid,
	output logic [2:0]             out_ch,
	output logic [`FIRE_WIDTH-1:0] out_data,
	output logic                   finish
);

	localparam int NOUT   = 2 * `FIRE_NCH;
	localparam int LANE_W = $clog2(`FIRE_NCH);

	fire_pkg::emit_state_t  state;
	logic [`FIRE_WIDTH-1:0] bank1 [`FIRE_NCH];
	logic [`FIRE_WIDTH-1:0] bank3 [`FIRE_NCH];
	logic                   pend1;
	logic                   pend3;
	logic                   ack_seen;
	logic [2:0]             cnt;

	always_ff @(posedge clk) begin
		if (s1) begin
			bank1 <= ofm1;
		end
		if (s3) begin
			bank3 <= ofm3;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= fire_pkg::EMIT_IDLE;
			cnt   <= '0;
			pend1 <= 1'b0;
			pend3 <= 1'b0;
		end else begin
			case (state)
				fire_pkg::EMIT_IDLE: begin
					if (pend1 && pend3) begin
						state <= fire_pkg::EMIT_BUSY;
						cnt   <= '0;
					end
				end
				fire_pkg::EMIT_BUSY: begin
					if (cnt == NOUT - 1) begin
						state <= fire_pkg::EMIT_IDLE;
						pend1 <= 1'b0;
						pend3 <= 1'b0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= fire_pkg::EMIT_IDLE;
			endcase
			// new results mark their engine pending
			if (s1) begin
				pend1 <= 1'b1;
			end
			if (s3) begin
				pend3 <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ack_seen <= 1'b0;
		end else if (ack) begin
			ack_seen <= 1'b1;
		end
	end

	// 1x1 lanes first, then 3x3
	assign out_valid = (state == fire_pkg::EMIT_BUSY);
	assign out_ch    = cnt;
	assign out_data  = cnt[LANE_W] ? bank3[cnt[LANE_W-1:0]] : bank1[cnt[LANE_W-1:0]];

	// nothing latched, pending or arriving
	assign finish = done1 && done3 && !ack_seen && (state == fire_pkg::EMIT_IDLE)
		&& !pend1 && !pend3 && !s1 && !s3;

endmodule

// ==== source/fire_config.svh ====
`ifndef FIRE_CONFIG_SVH
`define FIRE_CONFIG_SVH

// word width for pixels, weights and outputs
`define FIRE_WIDTH 16

// fraction bits of the fixed-point format
`define FIRE_FRAC 14

// output channels per expand engine
`define FIRE_NCH 4

// input channels from the squeeze layer
`define FIRE_CHIN 4

// output feature map is FIRE_WOUT x FIRE_WOUT
`define FIRE_WOUT 2

// full product plus one guard bit
`define FIRE_ACC_W (2 * `FIRE_WIDTH + 1)

// tap address wide enough for the 3x3 window
`define FIRE_TAP_W $clog2(9 * `FIRE_CHIN)

`endif

// ==== source/fire_expand_top.sv ====
`include "fire_config.svh"

module fire_expand_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   en1,
	input  logic [`FIRE_WIDTH-1:0] ifm1,
	input  logic                   en3,
	input  logic [`FIRE_WIDTH-1:0] ifm3,
	input  logic                   ack,
	output logic                   out_valid,
	output logic [2:0]             out_ch,
	output logic [`FIRE_WIDTH-1:0] out_data,
	output logic                   finish
);

	logic                   s1;
	logic                   s3;
	logic                   done1;
	logic                   done3;
	logic [`FIRE_WIDTH-1:0] ofm1 [`FIRE_NCH];
	logic [`FIRE_WIDTH-1:0] ofm3 [`FIRE_NCH];

	expand_conv #(
		.SEL(fire_pkg::KSEL_1X1)
	) i_exp1 (
		.clk   (clk),
		.rst   (rst),
		.en    (en1),
		.ifm   (ifm1),
		.sample(s1),
		.done  (done1),
		.ofm   (ofm1)
	);

	expand_conv #(
		.SEL(fire_pkg::KSEL_3X3)
	) i_exp3 (
		.clk   (clk),
		.rst   (rst),
		.en    (en3),
		.ifm   (ifm3),
		.sample(s3),
		.done  (done3),
		.ofm   (ofm3)
	);

	fire_concat i_concat (
		.clk      (clk),
		.rst      (rst),
		.s1       (s1),
		.ofm1     (ofm1),
		.s3       (s3),
		.ofm3     (ofm3),
		.done1    (done1),
		.done3    (done3),
		.ack      (ack),
		.out_valid(out_valid),
		.out_ch   (out_ch),
		.out_data (out_data),
		.finish   (finish)
	);

endmodule

// ==== source/fire_pkg.sv ====
package fire_pkg;

	// which constant table an expand engine reads
	typedef enum logic {
		KSEL_1X1,
		KSEL_3X3
	} kernel_sel_t;

	// combiner serialiser state
	typedef enum logic {
		EMIT_IDLE,
		EMIT_BUSY
	} emit_state_t;

endpackage

// ==== source/mac.sv ====
`include "fire_config.svh"

module mac (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          clr,
	input  logic                          en,
	input  logic signed [`FIRE_WIDTH-1:0] pix,
	input  logic signed [`FIRE_WIDTH-1:0] ker,
	output logic signed [`FIRE_ACC_W-1:0] acc
);

	logic signed [2*`FIRE_WIDTH-1:0] prod;

	assign prod = pix * ker;

	// clr starts the next window from the current product
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc <= '0;
		end else if (clr) begin
			if (en) begin
				acc <= `FIRE_ACC_W'(prod);
			end else begin
				acc <= '0;
			end
		end else if (en) begin
			acc <= acc + prod;
		end
	end

endmodule

// ==== sources.f ====
+incdir+source
source/fire_pkg.sv
source/mac.sv
source/expand_rom.sv
source/expand_conv.sv
source/fire_concat.sv
source/fire_expand_top.sv
dv/fire_expand_tb.sv
